/* build.f */
hw/sbfifo_cfg_pkg.sv
hw/sbfifo_msg_pkg.sv
hw/sbfifo_ptr_sync.sv
hw/sbfifo_ingress.sv
hw/sbfifo_egress.sv
hw/sbfifo_async.sv
sim/tb_sbfifo_async.sv

/* sim/tb_sbfifo_async.sv */
// directed testbench for sbfifo_async; expects QUEUE_DEPTH entries per queue and unrelated clocks
module tb_sbfifo_async;

  import sbfifo_cfg_pkg::*;
  import sbfifo_msg_pkg::*;

  // --------------------------------------------------------------------------
  // run geometry
  // --------------------------------------------------------------------------
  localparam int ING_HALF     = 2;                 // ingress period 4
  localparam int EGR_HALF     = 3;                 // egress period 6
  localparam int RESET_CYCLES = 10;
  localparam int N_ORDER      = 6;                 // single-flit messages per class
  localparam int TOTAL_FLITS  = 2*N_ORDER + QUEUE_DEPTH + 6 + 3 + 1;
  localparam int WATCHDOG_T   = (RESET_CYCLES + 40*TOTAL_FLITS) * 2*EGR_HALF;

  logic     ing_side_clk, ing_side_rst_b;
  logic     egr_side_clk, egr_side_rst_b;
  logic     pcirdy, npirdy, pctrdy, nptrdy, fifo_idle;
  sb_flit_t pc_flit, np_flit, out_flit;
  logic     parity_chk_en, epctrdy, enptrdy, epcirdy, enpirdy, parity_err_out;

  sb_flit_t    pc_model[$];                        // expected pc flits, oldest first
  sb_flit_t    np_model[$];
  logic        xfer_log[$];                        // class of each egress transfer, 1 = np
  int          owner;                              // class mid-message, -1 at a boundary
  int          errors;
  int          flits_checked;
  logic [31:0] rng_state;

  sbfifo_async uut (.*);

  always #ING_HALF ing_side_clk = ~ing_side_clk;
  always #EGR_HALF egr_side_clk = ~egr_side_clk;

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [7:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[23:16];                       // upper bits, better spread
  endfunction

  // even parity over data and eom, bad_par flips the parity bit
  function automatic sb_flit_t make_flit(input logic [7:0] data, input logic eom,
                                         input logic bad_par);
    sb_flit_t f;
    f.data   = data;
    f.eom    = eom;
    f.parity = (^data) ^ eom ^ bad_par;
    return f;
  endfunction

  task automatic flag_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_flit(input string name, input sb_flit_t got, input sb_flit_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ready never depends on valid, so sampling it at the falling edge is safe
  task automatic send_flit(input logic is_np, input sb_flit_t f);
    @(negedge ing_side_clk);
    if (is_np) begin
      npirdy  = 1'b1;
      np_flit = f;
    end else begin
      pcirdy  = 1'b1;
      pc_flit = f;
    end
    while (!(is_np ? nptrdy : pctrdy)) @(negedge ing_side_clk);
    if (is_np) np_model.push_back(f);            // moves on the coming rising edge
    else       pc_model.push_back(f);
    @(negedge ing_side_clk);
    pcirdy = 1'b0;
    npirdy = 1'b0;
  endtask

  task automatic wait_egr_cycles(input int n);
    repeat (n) @(negedge egr_side_clk);
  endtask

  task automatic drain_queues();
    int n;
    n = 0;
    while ((pc_model.size() > 0 || np_model.size() > 0) && n < 200) begin
      @(negedge egr_side_clk);
      n++;
    end
    if (n >= 200) flag_error("queues did not drain within 200 egress cycles");
  endtask

  task automatic wait_fifo_idle();
    int n;
    n = 0;
    @(negedge ing_side_clk);                       // fifo_idle lives in the ingress clock
    while (!fifo_idle && n < 20) begin
      @(negedge ing_side_clk);
      n++;
    end
    if (!fifo_idle) flag_error("fifo_idle did not return within 20 ingress cycles");
  endtask

  // --------------------------------------------------------------------------
  // egress monitor, a transfer is valid meeting its own ready on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge egr_side_clk) begin
    logic     is_np;
    logic     moved;
    sb_flit_t exp;
    is_np = enpirdy;
    moved = (epcirdy && epctrdy) || (enpirdy && enptrdy);
    if (egr_side_rst_b && epcirdy && enpirdy) flag_error("epcirdy and enpirdy both high");
    if (egr_side_rst_b && moved) begin
      if (owner >= 0 && owner != int'(is_np)) flag_error("message interleaved on the bus");
      owner = out_flit.eom ? -1 : int'(is_np);    // eom closes the message
      xfer_log.push_back(is_np);
      if ((is_np ? np_model.size() : pc_model.size()) == 0) begin
        flag_error("egress flit with nothing expected in its queue");
      end else begin
        exp = is_np ? np_model.pop_front() : pc_model.pop_front();
        check_flit(is_np ? "out_flit (np)" : "out_flit (pc)", out_flit, exp);
        flits_checked++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic reset_values();
    @(negedge ing_side_clk);
    check_bit("pctrdy", pctrdy, 1'b1);
    check_bit("nptrdy", nptrdy, 1'b1);
    check_bit("fifo_idle", fifo_idle, 1'b1);
    @(negedge egr_side_clk);
    check_bit("epcirdy", epcirdy, 1'b0);
    check_bit("enpirdy", enpirdy, 1'b0);
    check_bit("parity_err_out", parity_err_out, 1'b0);
  endtask

  task automatic queue_order();
    @(negedge egr_side_clk);
    epctrdy = 1'b1;
    enptrdy = 1'b1;
    for (int i = 0; i < N_ORDER; i++) send_flit(1'b0, make_flit(next_rand(), 1'b1, 1'b0));
    for (int i = 0; i < N_ORDER; i++) send_flit(1'b1, make_flit(next_rand(), 1'b1, 1'b0));
    drain_queues();
    wait_fifo_idle();
  endtask

  task automatic back_pressure();
    int accepted;
    @(negedge egr_side_clk);
    epctrdy = 1'b0;                                // stall pc at the egress
    @(negedge ing_side_clk);
    accepted = 0;
    pcirdy   = 1'b1;
    pc_flit  = make_flit(next_rand(), 1'b1, 1'b0);
    while (pctrdy && accepted <= QUEUE_DEPTH) begin
      pc_model.push_back(pc_flit);
      accepted++;
      @(negedge ing_side_clk);
      pc_flit = make_flit(next_rand(), 1'b1, 1'b0);
    end
    pcirdy = 1'b0;
    check_count("pc flits accepted under stall", accepted, QUEUE_DEPTH);
    check_bit("pctrdy", pctrdy, 1'b0);
    wait_egr_cycles(6);
    check_bit("pctrdy", pctrdy, 1'b0);             // still full while stalled
    @(negedge egr_side_clk);
    epctrdy = 1'b1;
    drain_queues();
    wait_fifo_idle();
    check_bit("pctrdy", pctrdy, 1'b1);
  endtask

  task automatic message_priority();
    logic exp_log[$];
    int   n;
    exp_log = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    xfer_log.delete();
    @(negedge egr_side_clk);
    epctrdy = 1'b0;
    enptrdy = 1'b0;
    send_flit(1'b1, make_flit(next_rand(), 1'b0, 1'b0));
    send_flit(1'b1, make_flit(next_rand(), 1'b0, 1'b0));
    send_flit(1'b1, make_flit(next_rand(), 1'b1, 1'b0));
    n = 0;
    @(negedge egr_side_clk);                       // egress ready moves on its own edges
    while (!enpirdy && n < 20) begin
      @(negedge egr_side_clk);
      n++;
    end
    if (!enpirdy) flag_error("np message never offered at the egress");
    enptrdy = 1'b1;                                // exactly one np flit goes
    @(negedge egr_side_clk);
    enptrdy = 1'b0;
    check_count("np flits out before the pc write", xfer_log.size(), 1);
    send_flit(1'b0, make_flit(next_rand(), 1'b0, 1'b0));
    send_flit(1'b0, make_flit(next_rand(), 1'b1, 1'b0));
    send_flit(1'b1, make_flit(next_rand(), 1'b1, 1'b0));
    wait_egr_cycles(8);                            // covers the pointer crossing
    check_bit("epcirdy", epcirdy, 1'b0);           // np still owns the bus
    check_bit("enpirdy", enpirdy, 1'b1);
    epctrdy = 1'b1;
    enptrdy = 1'b1;
    drain_queues();
    wait_fifo_idle();
    check_count("egress transfers", xfer_log.size(), exp_log.size());
    for (int i = 0; i < exp_log.size() && i < xfer_log.size(); i++) begin
      check_bit($sformatf("transfer %0d is np", i), xfer_log[i], exp_log[i]);
    end
  endtask

  task automatic parity_detect();
    send_flit(1'b0, make_flit(next_rand(), 1'b1, 1'b1));    // checking still off
    drain_queues();
    check_bit("parity_err_out", parity_err_out, 1'b0);
    @(negedge egr_side_clk);
    parity_chk_en = 1'b1;
    send_flit(1'b1, make_flit(next_rand(), 1'b1, 1'b1));
    drain_queues();
    check_bit("parity_err_out", parity_err_out, 1'b1);
    send_flit(1'b0, make_flit(next_rand(), 1'b1, 1'b0));    // good flit, error sticks
    drain_queues();
    check_bit("parity_err_out", parity_err_out, 1'b1);
    wait_fifo_idle();
  endtask

  task automatic idle_tracking();
    wait_fifo_idle();
    check_bit("fifo_idle", fifo_idle, 1'b1);
    @(negedge egr_side_clk);
    epctrdy = 1'b0;                                // keep the flit in the queue
    send_flit(1'b0, make_flit(next_rand(), 1'b1, 1'b0));
    check_bit("fifo_idle", fifo_idle, 1'b0);
    @(negedge egr_side_clk);
    epctrdy = 1'b1;
    drain_queues();
    wait_fifo_idle();
    check_bit("fifo_idle", fifo_idle, 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------
  initial begin
    #(WATCHDOG_T);
    $display("watchdog: run timed out after %0d time units", WATCHDOG_T);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    ing_side_clk   = 1'b0;
    egr_side_clk   = 1'b0;
    ing_side_rst_b = 1'b0;
    egr_side_rst_b = 1'b0;
    pcirdy         = 1'b0;
    npirdy         = 1'b0;
    pc_flit        = '0;
    np_flit        = '0;
    parity_chk_en  = 1'b0;
    epctrdy        = 1'b0;
    enptrdy        = 1'b0;
    owner          = -1;
    errors         = 0;
    flits_checked  = 0;
    rng_state      = 32'h66ee;
    fork                                           // each reset follows its own clock
      begin
        repeat (RESET_CYCLES) @(negedge ing_side_clk);
        ing_side_rst_b = 1'b1;
      end
      begin
        repeat (RESET_CYCLES) @(negedge egr_side_clk);
        egr_side_rst_b = 1'b1;
      end
    join
    reset_values();
    queue_order();
    back_pressure();
    message_priority();
    parity_detect();
    idle_tracking();
    $display("summary: %0d errors, %0d flits checked", errors, flits_checked);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* hw/sbfifo_async.sv */
// two-queue sideband clock-crossing FIFO; the two clocks may be fully unrelated
module sbfifo_async (
  // ingress domain
  input  logic                     ing_side_clk,
  input  logic                     ing_side_rst_b,
  input  logic                     pcirdy,
  input  sbfifo_msg_pkg::sb_flit_t pc_flit,
  output logic                     pctrdy,
  input  logic                     npirdy,
  input  sbfifo_msg_pkg::sb_flit_t np_flit,
  output logic                     nptrdy,
  output logic                     fifo_idle,

  // egress domain
  input  logic                     egr_side_clk,
  input  logic                     egr_side_rst_b,
  input  logic                     parity_chk_en,
  input  logic                     epctrdy,
  input  logic                     enptrdy,
  output logic                     epcirdy,
  output logic                     enpirdy,
  output sbfifo_msg_pkg::sb_flit_t out_flit,
  output logic                     parity_err_out
);

  import sbfifo_cfg_pkg::*;
  import sbfifo_msg_pkg::*;

  // --------------------------------------------------------------------------
  // crossing wires
  // --------------------------------------------------------------------------
  sb_ptr_t  pc_wptr_gray, np_wptr_gray;           // ingress -> sync
  sb_ptr_t  pc_wptr_sync, np_wptr_sync;           // sync -> egress
  sb_ptr_t  pc_rptr_gray, np_rptr_gray;           // egress -> sync
  sb_ptr_t  pc_rptr_sync, np_rptr_sync;           // sync -> ingress
  sb_ptr_t  pc_raddr, np_raddr;                   // storage read index
  sb_flit_t pc_rdata, np_rdata;                   // storage read data

  sbfifo_ingress u_ing (
    .ing_side_clk, .ing_side_rst_b,
    .pcirdy, .pc_flit, .pctrdy,
    .npirdy, .np_flit, .nptrdy,
    .pc_rptr_sync, .np_rptr_sync,
    .pc_wptr_gray, .np_wptr_gray,
    .pc_raddr, .np_raddr,
    .pc_rdata, .np_rdata,
    .fifo_idle
  );

  sbfifo_egress u_egr (
    .egr_side_clk, .egr_side_rst_b,
    .parity_chk_en,
    .pc_wptr_sync, .np_wptr_sync,
    .pc_rptr_gray, .np_rptr_gray,
    .pc_rdata, .np_rdata,
    .pc_raddr, .np_raddr,
    .epctrdy, .enptrdy, .epcirdy, .enpirdy,
    .out_flit,
    .parity_err_out
  );

  // write pointers into the egress clock
  sbfifo_ptr_sync u_pc_wsync (.dst_clk(egr_side_clk), .dst_rst_b(egr_side_rst_b),
                              .gray_in(pc_wptr_gray), .gray_out(pc_wptr_sync));
  sbfifo_ptr_sync u_np_wsync (.dst_clk(egr_side_clk), .dst_rst_b(egr_side_rst_b),
                              .gray_in(np_wptr_gray), .gray_out(np_wptr_sync));

  // read pointers back into the ingress clock
  sbfifo_ptr_sync u_pc_rsync (.dst_clk(ing_side_clk), .dst_rst_b(ing_side_rst_b),
                              .gray_in(pc_rptr_gray), .gray_out(pc_rptr_sync));
  sbfifo_ptr_sync u_np_rsync (.dst_clk(ing_side_clk), .dst_rst_b(ing_side_rst_b),
                              .gray_in(np_rptr_gray), .gray_out(np_rptr_sync));

endmodule

/* hw/sbfifo_egress.sv */
// read side in the egress clock; messages are never interleaved, pc wins only at a boundary
module sbfifo_egress (
  input  logic                     egr_side_clk,
  input  logic                     egr_side_rst_b,

  // configuration
  input  logic                     parity_chk_en,   // static while traffic flows

  // pointer crossing
  input  sbfifo_cfg_pkg::sb_ptr_t  pc_wptr_sync,    // gray write ptr, synced in
  input  sbfifo_cfg_pkg::sb_ptr_t  np_wptr_sync,
  output sbfifo_cfg_pkg::sb_ptr_t  pc_rptr_gray,    // registered gray read ptr
  output sbfifo_cfg_pkg::sb_ptr_t  np_rptr_gray,

  // storage read access
  input  sbfifo_msg_pkg::sb_flit_t pc_rdata,
  input  sbfifo_msg_pkg::sb_flit_t np_rdata,
  output sbfifo_cfg_pkg::sb_ptr_t  pc_raddr,
  output sbfifo_cfg_pkg::sb_ptr_t  np_raddr,

  // shared flit bus
  input  logic                     epctrdy,
  input  logic                     enptrdy,
  output logic                     epcirdy,
  output logic                     enpirdy,
  output sbfifo_msg_pkg::sb_flit_t out_flit,

  // status
  output logic                     parity_err_out   // sticky until reset
);

  import sbfifo_cfg_pkg::*;
  import sbfifo_msg_pkg::*;

  // --------------------------------------------------------------------------
  // per-queue arrays
  // --------------------------------------------------------------------------
  logic     [NUM_Q-1:0] q_empty;
  logic     [NUM_Q-1:0] sel;                        // queue that owns the bus
  logic     [NUM_Q-1:0] irdy;                       // valid per queue
  logic     [NUM_Q-1:0] trdy;                       // consumer ready per queue
  logic     [NUM_Q-1:0] pop;                        // flit transferred
  sb_ptr_t              wptr_gs  [NUM_Q];
  sb_ptr_t              rptr_go  [NUM_Q];
  sb_ptr_t              raddr    [NUM_Q];
  sb_flit_t             rdata    [NUM_Q];

  sb_arb_e  arb_q;                                  // arbiter state
  sb_arb_e  arb_nxt;
  logic     xfer;                                   // any flit moved this cycle
  logic     par_err_q;

  assign wptr_gs[Q_PC] = pc_wptr_sync;
  assign wptr_gs[Q_NP] = np_wptr_sync;
  assign rdata[Q_PC]   = pc_rdata;
  assign rdata[Q_NP]   = np_rdata;
  assign trdy[Q_PC]    = epctrdy;
  assign trdy[Q_NP]    = enptrdy;

  // --------------------------------------------------------------------------
  // read pointers, one set per queue
  // --------------------------------------------------------------------------
  for (genvar q = 0; q < NUM_Q; q++) begin : g_q

    sb_ptr_t rptr;                                  // binary read pointer
    sb_ptr_t rptr_nxt;
    sb_ptr_t rptr_g;                                // registered gray copy
    sb_ptr_t wptr_bin;

    assign wptr_bin   = gray2bin(wptr_gs[q]);
    assign q_empty[q] = (rptr == wptr_bin);         // new data shows after sync delay
    assign rptr_nxt   = rptr + sb_ptr_t'(pop[q]);

    always_ff @(posedge egr_side_clk or negedge egr_side_rst_b) begin
      if (!egr_side_rst_b) begin
        rptr   <= '0;
        rptr_g <= '0;
      end else begin
        rptr   <= rptr_nxt;
        rptr_g <= bin2gray(rptr_nxt);               // frees the slot toward ingress
      end
    end

    assign raddr[q]   = rptr;
    assign rptr_go[q] = rptr_g;

  end : g_q

  // --------------------------------------------------------------------------
  // bus ownership
  // --------------------------------------------------------------------------
  // idle grants straight away so a lone flit is offered the cycle it shows up
  always_comb begin
    sel = '0;
    case (arb_q)
      ARB_PC:  sel[Q_PC] = 1'b1;                    // hold for the rest of the message
      ARB_NP:  sel[Q_NP] = 1'b1;
      default: begin
        if (!q_empty[Q_PC]) begin
          sel[Q_PC] = 1'b1;                         // pc first at a boundary
        end else begin
          sel[Q_NP] = 1'b1;
        end
      end
    endcase
  end

  assign irdy     = sel & ~q_empty;
  assign pop      = irdy & trdy;
  assign xfer     = |pop;
  assign out_flit = sel[Q_PC] ? rdata[Q_PC] : rdata[Q_NP];

  // lock onto an offered queue so a stalled flit stays put
  always_comb begin
    arb_nxt = arb_q;
    case (arb_q)
      ARB_PC, ARB_NP: arb_nxt = arb_q;
      default: begin
        arb_nxt = ARB_IDLE;                         // also recovers an unused code
        if (irdy[Q_PC]) begin
          arb_nxt = ARB_PC;
        end else if (irdy[Q_NP]) begin
          arb_nxt = ARB_NP;
        end
      end
    endcase
    if (xfer && out_flit.eom) begin
      arb_nxt = ARB_IDLE;                           // message done, back to a boundary
    end
  end

  always_ff @(posedge egr_side_clk or negedge egr_side_rst_b) begin
    if (!egr_side_rst_b) begin
      arb_q     <= ARB_IDLE;
      par_err_q <= 1'b0;
    end else begin
      arb_q     <= arb_nxt;
      // only flits that actually move are checked
      if (xfer && parity_chk_en && flit_par_err(out_flit)) begin
        par_err_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  assign epcirdy        = irdy[Q_PC];
  assign enpirdy        = irdy[Q_NP];               // sel is one-hot, never both
  assign pc_raddr       = raddr[Q_PC];
  assign np_raddr       = raddr[Q_NP];
  assign pc_rptr_gray   = rptr_go[Q_PC];
  assign np_rptr_gray   = rptr_go[Q_NP];
  assign parity_err_out = par_err_q;

endmodule

/* hw/sbfifo_ingress.sv */
// write side of both queues in the ingress clock; ready is ~full and never looks at valid
module sbfifo_ingress (
  input  logic                     ing_side_clk,
  input  logic                     ing_side_rst_b,

  // pc channel
  input  logic                     pcirdy,
  input  sbfifo_msg_pkg::sb_flit_t pc_flit,
  output logic                     pctrdy,

  // np channel
  input  logic                     npirdy,
  input  sbfifo_msg_pkg::sb_flit_t np_flit,
  output logic                     nptrdy,

  // pointer crossing
  input  sbfifo_cfg_pkg::sb_ptr_t  pc_rptr_sync,   // gray read ptr, already synced in
  input  sbfifo_cfg_pkg::sb_ptr_t  np_rptr_sync,
  output sbfifo_cfg_pkg::sb_ptr_t  pc_wptr_gray,   // registered gray write ptr, goes out
  output sbfifo_cfg_pkg::sb_ptr_t  np_wptr_gray,

  // egress read access into the storage
  input  sbfifo_cfg_pkg::sb_ptr_t  pc_raddr,
  input  sbfifo_cfg_pkg::sb_ptr_t  np_raddr,
  output sbfifo_msg_pkg::sb_flit_t pc_rdata,
  output sbfifo_msg_pkg::sb_flit_t np_rdata,

  // status
  output logic                     fifo_idle       // both queues empty, ingress view
);

  import sbfifo_cfg_pkg::*;
  import sbfifo_msg_pkg::*;

  // --------------------------------------------------------------------------
  // gather both channels into per-queue arrays
  // --------------------------------------------------------------------------
  logic     [NUM_Q-1:0] irdy;                      // producer valid
  logic     [NUM_Q-1:0] trdy;                      // queue has room
  logic     [NUM_Q-1:0] push;                      // flit accepted this cycle
  logic     [NUM_Q-1:0] q_empty;                   // ingress view of empty
  sb_flit_t             wdata    [NUM_Q];
  sb_ptr_t              rptr_gs  [NUM_Q];          // synced gray read pointers
  sb_ptr_t              raddr    [NUM_Q];
  sb_ptr_t              wptr_go  [NUM_Q];          // gray write pointers out
  sb_flit_t             rdata    [NUM_Q];

  assign irdy[Q_PC]    = pcirdy;
  assign irdy[Q_NP]    = npirdy;
  assign wdata[Q_PC]   = pc_flit;
  assign wdata[Q_NP]   = np_flit;
  assign rptr_gs[Q_PC] = pc_rptr_sync;
  assign rptr_gs[Q_NP] = np_rptr_sync;
  assign raddr[Q_PC]   = pc_raddr;
  assign raddr[Q_NP]   = np_raddr;

  // --------------------------------------------------------------------------
  // one queue per class, identical logic
  // --------------------------------------------------------------------------
  for (genvar q = 0; q < NUM_Q; q++) begin : g_q

    sb_flit_t mem [QUEUE_DEPTH];                   // flop storage, no reset
    sb_ptr_t  wptr;                                // binary write pointer
    sb_ptr_t  wptr_nxt;
    sb_ptr_t  wptr_g;                              // registered gray copy
    sb_ptr_t  rptr_bin;                            // read pointer back in binary

    assign rptr_bin = gray2bin(rptr_gs[q]);

    // full drops ready the cycle right after the last free slot is taken
    assign trdy[q]    = ~ptr_full(wptr, rptr_bin);
    assign q_empty[q] = (wptr == rptr_bin);        // may lag egress reads by sync delay
    assign push[q]    = irdy[q] & trdy[q];
    assign wptr_nxt   = wptr + sb_ptr_t'(push[q]);

    always_ff @(posedge ing_side_clk or negedge ing_side_rst_b) begin
      if (!ing_side_rst_b) begin
        wptr   <= '0;
        wptr_g <= '0;
      end else begin
        wptr   <= wptr_nxt;
        wptr_g <= bin2gray(wptr_nxt);              // moves with the entry write
      end
    end

    // storage write on each accepted flit
    always_ff @(posedge ing_side_clk) begin
      if (push[q]) begin
        mem[wptr[ADDR_W-1:0]] <= wdata[q];
      end
    end

    // egress only points here after the gray write ptr has crossed
    assign rdata[q]   = mem[raddr[q][ADDR_W-1:0]];
    assign wptr_go[q] = wptr_g;

  end : g_q

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  assign pctrdy       = trdy[Q_PC];
  assign nptrdy       = trdy[Q_NP];
  assign pc_wptr_gray = wptr_go[Q_PC];
  assign np_wptr_gray = wptr_go[Q_NP];
  assign pc_rdata     = rdata[Q_PC];
  assign np_rdata     = rdata[Q_NP];

  assign fifo_idle    = &q_empty;                  // high out of reset

endmodule

/* hw/sbfifo_ptr_sync.sv */
// two-flop synchronizer for a gray pointer; input must change at most one bit per source clock
module sbfifo_ptr_sync (
  input  logic                    dst_clk,
  input  logic                    dst_rst_b,
  input  sbfifo_cfg_pkg::sb_ptr_t gray_in,   // gray pointer from the other domain
  output sbfifo_cfg_pkg::sb_ptr_t gray_out   // same pointer, two dst_clk later
);

  import sbfifo_cfg_pkg::*;

  sb_ptr_t meta_q;                           // first stage, may go metastable
  sb_ptr_t sync_q;                           // second stage, safe to use

  // --------------------------------------------------------------------------
  // per-bit double flop
  // --------------------------------------------------------------------------
  // gray coding keeps a multi-bit capture to one of two neighbouring values
  always_ff @(posedge dst_clk or negedge dst_rst_b) begin
    if (!dst_rst_b) begin
      meta_q <= '0;                          // both sides reset to pointer 0
      sync_q <= '0;
    end else begin
      meta_q <= gray_in;
      sync_q <= meta_q;
    end
  end

  assign gray_out = sync_q;

endmodule

/* hw/sbfifo_msg_pkg.sv */
// flit layout and egress arbiter states; parity is even over data, eom and the parity bit
package sbfifo_msg_pkg;

  // --------------------------------------------------------------------------
  // flit
  // --------------------------------------------------------------------------
  localparam int PLD_W = 8;                          // payload bits per flit

  // one bus beat, 10 bits in all
  typedef struct packed {
    logic             eom;                           // last flit of the message
    logic             parity;                        // makes ^{data,eom,parity} == 0
    logic [PLD_W-1:0] data;                          // payload byte
  } sb_flit_t;

  // --------------------------------------------------------------------------
  // egress arbitration
  // --------------------------------------------------------------------------
  // ARB_IDLE  at a message boundary, next grant is open (pc wins)
  // ARB_PC    pc message in flight, bus held until eom goes
  // ARB_NP    np message in flight, same rule
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_PC   = 2'd1,
    ARB_NP   = 2'd2
  } sb_arb_e;

  // high when the flit breaks the even parity rule
  function automatic logic flit_par_err(input sb_flit_t flit);
    return ^flit;                                    // covers eom, parity and data
  endfunction

endpackage

/* hw/sbfifo_cfg_pkg.sv */
// queue geometry for both queues; QUEUE_DEPTH must be a power of two, pointers carry a wrap bit
package sbfifo_cfg_pkg;

  // --------------------------------------------------------------------------
  // geometry
  // --------------------------------------------------------------------------
  localparam int QUEUE_DEPTH = 4;                    // entries per queue
  localparam int ADDR_W      = $clog2(QUEUE_DEPTH);  // storage index bits
  localparam int PTR_W       = ADDR_W + 1;           // index plus wrap bit for full/empty

  localparam int NUM_Q       = 2;                    // one queue per traffic class
  localparam int Q_PC        = 0;                    // posted / completion
  localparam int Q_NP        = 1;                    // non-posted

  // one pointer word, holds either the binary or the gray form
  typedef logic [PTR_W-1:0] sb_ptr_t;

  // --------------------------------------------------------------------------
  // gray code helpers, only single-bit steps may cross a clock boundary
  // --------------------------------------------------------------------------
  function automatic sb_ptr_t bin2gray(input sb_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic sb_ptr_t gray2bin(input sb_ptr_t gray);
    sb_ptr_t bin;
    bin[PTR_W-1] = gray[PTR_W-1];                    // msb passes through
    for (int i = PTR_W-2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];                   // running xor down to lsb
    end
    return bin;
  endfunction

  // full when index bits match and the wrap bits differ
  function automatic logic ptr_full(input sb_ptr_t wptr, input sb_ptr_t rptr);
    return (wptr[ADDR_W-1:0] == rptr[ADDR_W-1:0]) &&
           (wptr[PTR_W-1] != rptr[PTR_W-1]);
  endfunction

endpackage
